// File: logic/xbuf_pkg.sv
// Operand staging shared definitions

package xbuf_pkg;

  // Operand element and systolic array geometry
  localparam int unsigned ELEM_W    = 16;
  localparam int unsigned ARRAY_H   = 4;
  localparam int unsigned ARRAY_W   = 4;

  // Pad slots per row, two banks worth of rows
  localparam int unsigned PAD_DEPTH = 2 * ARRAY_H;

  // One load word carries a full pad row, slot 0 in the low bits
  localparam int unsigned DATA_W    = PAD_DEPTH * ELEM_W;

  // Derived widths
  localparam int unsigned SLOT_AW   = $clog2(PAD_DEPTH);
  localparam int unsigned CNT_W     = SLOT_AW + 1;
  localparam int unsigned WIDX_W    = $clog2(ARRAY_W) + 1;
  localparam int unsigned ROW_AW    = $clog2(ARRAY_H);
  localparam int unsigned BCNT_W    = ROW_AW + 1;

  // Rows held by both buffer banks together
  localparam int unsigned BUF_ROWS  = 2 * ARRAY_H;

  // Fill FSM states
  typedef enum logic [2:0] {
    PRELOAD,
    FAST_FILL,
    WAIT_FIRST_READ,
    FILL,
    PAD_EMPTY
  } xbuf_state_e;

endpackage

// File: logic/x_pad_mem.sv
// Operand pad memory

module x_pad_mem (
  input  logic                                            clk_i,
  input  logic                                            rst_ni,
  input  logic                                            clear_i,
  input  logic                                            we_i,
  input  logic [xbuf_pkg::WIDX_W-1:0]                     waddr_i,
  input  logic [xbuf_pkg::DATA_W-1:0]                     wdata_i,
  input  logic                                            rd_en_i,
  input  logic [xbuf_pkg::SLOT_AW-1:0]                    raddr_i,
  output logic [xbuf_pkg::ARRAY_W-1:0][xbuf_pkg::ELEM_W-1:0] rdata_o
);
  import xbuf_pkg::*;

  // One pad row per array column, PAD_DEPTH slots each
  logic [ARRAY_W-1:0][PAD_DEPTH-1:0][ELEM_W-1:0] mem_q;
  logic [ARRAY_W-1:0][ELEM_W-1:0]                rdata_q;

  // Row write, the whole load word lands in one pad row
  for (genvar r = 0; r < ARRAY_W; r++) begin : g_row
    always_ff @(posedge clk_i) begin
      if (we_i && (waddr_i == WIDX_W'(r))) begin
        mem_q[r] <= wdata_i;
      end
    end
  end

  // Column read
  // The same slot is taken from every row, so the output word is
  // one slot across all columns
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (clear_i) begin
      rdata_q <= '0;
    end else if (rd_en_i) begin
      for (int r = 0; r < ARRAY_W; r++) begin
        rdata_q[r] <= mem_q[r][raddr_i];
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule

// File: logic/x_shift_buf.sv
// Two-bank operand shift buffer

module x_shift_buf (
  input  logic                                             clk_i,
  input  logic                                             rst_ni,
  input  logic                                             clear_i,
  input  logic                                             we_i,
  input  logic                                             wbank_i,
  input  logic [xbuf_pkg::ROW_AW-1:0]                      wrow_i,
  input  logic [xbuf_pkg::ARRAY_W-1:0][xbuf_pkg::ELEM_W-1:0] wdata_i,
  input  logic                                             zero_i,
  input  logic                                             rbank_i,
  output logic [xbuf_pkg::ARRAY_H-1:0][xbuf_pkg::ARRAY_W-1:0][xbuf_pkg::ELEM_W-1:0] rdata_o
);
  import xbuf_pkg::*;

  logic [1:0][ARRAY_H-1:0][ARRAY_W-1:0][ELEM_W-1:0] bank_q;
  logic [ARRAY_W-1:0][ELEM_W-1:0]                   row_data;

  // Rows past the programmed height are stored as zeros
  assign row_data = zero_i ? '0 : wdata_i;

  for (genvar b = 0; b < 2; b++) begin : g_bank
    for (genvar h = 0; h < ARRAY_H; h++) begin : g_row
      logic row_we;

      assign row_we = we_i && (wbank_i == b[0]) && (wrow_i == ROW_AW'(h));

      always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
          bank_q[b][h] <= '0;
        end else if (clear_i) begin
          bank_q[b][h] <= '0;
        end else if (row_we) begin
          bank_q[b][h] <= row_data;
        end
      end
    end
  end

  // Whole read bank goes to the array at once
  assign rdata_o = bank_q[rbank_i];

endmodule

// File: logic/x_buffer_ctrl.sv
// Operand staging fill controller

module x_buffer_ctrl (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         clear_i,
  input  logic                         load_i,
  input  logic                         rst_w_index_i,
  input  logic                         pad_setup_i,
  input  logic                         h_shift_i,
  input  logic [xbuf_pkg::WIDX_W-1:0]  width_i,
  input  logic [xbuf_pkg::SLOT_AW-1:0] height_i,
  input  logic [xbuf_pkg::CNT_W-1:0]   slots_i,
  output logic [xbuf_pkg::WIDX_W-1:0]  w_index_o,
  output logic                         full_o,
  output logic                         empty_o,
  output logic                         bank_valid_o,
  output logic                         pad_rd_en_o,
  output logic [xbuf_pkg::SLOT_AW-1:0] pad_rd_addr_o,
  output logic                         buf_we_o,
  output logic                         buf_wbank_o,
  output logic [xbuf_pkg::ROW_AW-1:0]  buf_wrow_o,
  output logic                         buf_zero_o,
  output logic                         buf_rbank_o
);
  import xbuf_pkg::*;

  xbuf_state_e               state_q, state_d;
  logic [WIDX_W-1:0]         w_index_q;
  logic [SLOT_AW-1:0]        rd_slot_q, cons_slot_q;
  logic [CNT_W-1:0]          lvl_q, lvl_d;
  logic [ROW_AW-1:0]         wrow_q, rrow_q;
  logic                      wbank_q, rbank_q, rbank_d;
  logic [1:0][BCNT_W-1:0]    wr_cnt_q, wr_cnt_d;
  logic                      we_q, zero_q, empty_q, valid_q;
  logic                      shift, free, room, rd_go, last_slot;

  // Next slot, wrapping modulo the programmed slot count
  function automatic logic [SLOT_AW-1:0] slot_step(logic [SLOT_AW-1:0] s,
                                                   logic [CNT_W-1:0]   n);
    if ({1'b0, s} >= n - CNT_W'(1)) begin
      return '0;
    end
    return s + SLOT_AW'(1);
  endfunction

  // Loaded-row counter, held until the host acknowledges full
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      w_index_q <= '0;
    end else if (clear_i || rst_w_index_i) begin
      w_index_q <= '0;
    end else if (load_i) begin
      w_index_q <= w_index_q + WIDX_W'(1);
    end
  end

  assign w_index_o = w_index_q;
  assign full_o    = (w_index_q == width_i);

  // Shifts only count while the array sees a complete bank
  assign shift     = h_shift_i && valid_q;
  assign free      = shift && (rrow_q == ROW_AW'(ARRAY_H - 1));
  assign last_slot = shift && (slot_step(cons_slot_q, slots_i) == '0);
  // lvl_q counts rows reserved by a pad read and not yet freed
  assign room      = (lvl_q < CNT_W'(BUF_ROWS)) || free;

  always_comb begin
    rd_go = 1'b0;
    case (state_q)
      FAST_FILL:       rd_go = room;
      WAIT_FIRST_READ: rd_go = free;
      FILL, PAD_EMPTY: rd_go = shift && room;
      default:         rd_go = 1'b0;
    endcase
  end

  assign pad_rd_en_o   = pad_setup_i || rd_go;
  assign pad_rd_addr_o = pad_setup_i ? '0 : rd_slot_q;

  always_comb begin
    lvl_d = lvl_q;
    if (pad_setup_i) begin
      lvl_d = CNT_W'(1);
    end else begin
      if (rd_go) begin
        lvl_d = lvl_d + CNT_W'(1);
      end
      if (free) begin
        lvl_d = lvl_d - CNT_W'(ARRAY_H);
      end
    end
  end

  always_comb begin
    state_d = state_q;
    if (pad_setup_i) begin
      state_d = FAST_FILL;
    end else begin
      case (state_q)
        FAST_FILL: begin
          if (lvl_d == CNT_W'(BUF_ROWS)) begin
            state_d = WAIT_FIRST_READ;
          end
        end
        WAIT_FIRST_READ: begin
          if (last_slot) begin
            state_d = PAD_EMPTY;
          end else if (free) begin
            state_d = FILL;
          end
        end
        FILL: begin
          if (last_slot) begin
            state_d = PAD_EMPTY;
          end
        end
        PAD_EMPTY: begin
          // Delivery restarts from slot 0 of the same pad
          if (shift && !last_slot) begin
            state_d = FILL;
          end
        end
        default: state_d = state_q;
      endcase
    end
  end

  // Bank fill levels, the freed bank is emptied before a landing write counts
  always_comb begin
    wr_cnt_d = wr_cnt_q;
    if (free) begin
      wr_cnt_d[rbank_q] = '0;
    end
    if (we_q) begin
      wr_cnt_d[wbank_q] = wr_cnt_d[wbank_q] + BCNT_W'(1);
    end
  end

  assign rbank_d = free ? ~rbank_q : rbank_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= PRELOAD;
      lvl_q       <= '0;
      rd_slot_q   <= '0;
      cons_slot_q <= '0;
      we_q        <= 1'b0;
      zero_q      <= 1'b0;
      empty_q     <= 1'b0;
      valid_q     <= 1'b0;
      wbank_q     <= 1'b0;
      wrow_q      <= '0;
      rbank_q     <= 1'b0;
      rrow_q      <= '0;
      wr_cnt_q    <= '0;
    end else if (clear_i) begin
      state_q     <= PRELOAD;
      lvl_q       <= '0;
      rd_slot_q   <= '0;
      cons_slot_q <= '0;
      we_q        <= 1'b0;
      zero_q      <= 1'b0;
      empty_q     <= 1'b0;
      valid_q     <= 1'b0;
      wbank_q     <= 1'b0;
      wrow_q      <= '0;
      rbank_q     <= 1'b0;
      rrow_q      <= '0;
      wr_cnt_q    <= '0;
    end else begin
      state_q <= state_d;
      lvl_q   <= lvl_d;
      // Buffer write follows the pad read by one cycle
      we_q    <= pad_rd_en_o;
      empty_q <= last_slot && !pad_setup_i;
      if (pad_rd_en_o) begin
        zero_q    <= (pad_rd_addr_o > height_i);
        rd_slot_q <= slot_step(pad_rd_addr_o, slots_i);
      end
      if (pad_setup_i) begin
        cons_slot_q <= '0;
        valid_q     <= 1'b0;
        wbank_q     <= 1'b0;
        wrow_q      <= '0;
        rbank_q     <= 1'b0;
        rrow_q      <= '0;
        wr_cnt_q    <= '0;
      end else begin
        if (shift) begin
          cons_slot_q <= slot_step(cons_slot_q, slots_i);
          rrow_q      <= free ? '0 : rrow_q + ROW_AW'(1);
        end
        rbank_q <= rbank_d;
        if (we_q) begin
          if (wrow_q == ROW_AW'(ARRAY_H - 1)) begin
            wrow_q  <= '0;
            wbank_q <= ~wbank_q;
          end else begin
            wrow_q <= wrow_q + ROW_AW'(1);
          end
        end
        wr_cnt_q <= wr_cnt_d;
        valid_q  <= (wr_cnt_d[rbank_d] == BCNT_W'(ARRAY_H));
      end
    end
  end

  assign empty_o      = empty_q;
  assign bank_valid_o = valid_q;
  assign buf_we_o     = we_q;
  assign buf_wbank_o  = wbank_q;
  assign buf_wrow_o   = wrow_q;
  assign buf_zero_o   = zero_q;
  assign buf_rbank_o  = rbank_q;

endmodule

// File: logic/x_buffer.sv
// Matrix engine input operand staging
// Pad memory, shift buffer and fill control

module x_buffer (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         clear_i,
  input  logic                         load_i,
  input  logic [xbuf_pkg::DATA_W-1:0]  data_i,
  input  logic [xbuf_pkg::WIDX_W-1:0]  width_i,
  input  logic                         rst_w_index_i,
  input  logic                         pad_setup_i,
  input  logic [xbuf_pkg::CNT_W-1:0]   slots_i,
  input  logic [xbuf_pkg::SLOT_AW-1:0] height_i,
  input  logic                         h_shift_i,
  output logic [xbuf_pkg::ARRAY_W-1:0][xbuf_pkg::ARRAY_H-1:0][xbuf_pkg::ELEM_W-1:0] x_buffer_o,
  output logic                         full_o,
  output logic                         empty_o,
  output logic                         bank_valid_o
);
  import xbuf_pkg::*;

  logic [WIDX_W-1:0]                     w_index;
  logic                                  pad_rd_en;
  logic [SLOT_AW-1:0]                    pad_rd_addr;
  logic [ARRAY_W-1:0][ELEM_W-1:0]        pad_col;
  logic                                  buf_we;
  logic                                  buf_wbank;
  logic [ROW_AW-1:0]                     buf_wrow;
  logic                                  buf_zero;
  logic                                  buf_rbank;
  logic [ARRAY_H-1:0][ARRAY_W-1:0][ELEM_W-1:0] bank_rows;

  x_pad_mem i_pad (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .clear_i (clear_i),
    .we_i    (load_i),
    .waddr_i (w_index),
    .wdata_i (data_i),
    .rd_en_i (pad_rd_en),
    .raddr_i (pad_rd_addr),
    .rdata_o (pad_col)
  );

  x_shift_buf i_buf (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .clear_i (clear_i),
    .we_i    (buf_we),
    .wbank_i (buf_wbank),
    .wrow_i  (buf_wrow),
    .wdata_i (pad_col),
    .zero_i  (buf_zero),
    .rbank_i (buf_rbank),
    .rdata_o (bank_rows)
  );

  x_buffer_ctrl i_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .clear_i       (clear_i),
    .load_i        (load_i),
    .rst_w_index_i (rst_w_index_i),
    .pad_setup_i   (pad_setup_i),
    .h_shift_i     (h_shift_i),
    .width_i       (width_i),
    .height_i      (height_i),
    .slots_i       (slots_i),
    .w_index_o     (w_index),
    .full_o        (full_o),
    .empty_o       (empty_o),
    .bank_valid_o  (bank_valid_o),
    .pad_rd_en_o   (pad_rd_en),
    .pad_rd_addr_o (pad_rd_addr),
    .buf_we_o      (buf_we),
    .buf_wbank_o   (buf_wbank),
    .buf_wrow_o    (buf_wrow),
    .buf_zero_o    (buf_zero),
    .buf_rbank_o   (buf_rbank)
  );

  // Array columns take element w of every buffered row
  for (genvar w = 0; w < ARRAY_W; w++) begin : g_col
    for (genvar h = 0; h < ARRAY_H; h++) begin : g_row
      assign x_buffer_o[w][h] = bank_rows[h][w];
    end
  end

endmodule

// File: test/x_buffer_asserts.sv
// Fill controller protocol assertions

module x_buffer_asserts (
  input logic                  clk_i,
  input logic                  rst_ni,
  input logic                  clear_i,
  input xbuf_pkg::xbuf_state_e state_q,
  input logic                  full_o,
  input logic                  empty_o,
  input logic                  bank_valid_o,
  input logic                  buf_we_o,
  input logic                  buf_wbank_o,
  input logic                  buf_rbank_o
);
  timeunit 1ns;
  timeprecision 1ps;
  import xbuf_pkg::*;

  // A clear leaves the FSM idle with every flag low
  clear_drops_flags: assert property (@(posedge clk_i) disable iff (!rst_ni)
    clear_i |=> (state_q == PRELOAD) && !full_o && !empty_o && !bank_valid_o)
    else $error("state or flags still set after clear_i");

  // Nothing is consumed before the first pad setup
  no_empty_in_preload: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == PRELOAD) |-> !empty_o)
    else $error("empty_o high in PRELOAD");

  // Refill writes never land in the bank the array is reading
  no_write_to_read_bank: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (buf_we_o && bank_valid_o) |-> (buf_wbank_o != buf_rbank_o))
    else $error("buffer write targets the valid read bank");

endmodule

bind x_buffer_ctrl x_buffer_asserts i_asserts (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .clear_i      (clear_i),
  .state_q      (state_q),
  .full_o       (full_o),
  .empty_o      (empty_o),
  .bank_valid_o (bank_valid_o),
  .buf_we_o     (buf_we_o),
  .buf_wbank_o  (buf_wbank_o),
  .buf_rbank_o  (buf_rbank_o)
);

// File: test/tb_x_buffer.sv
// Operand staging testbench

module tb_x_buffer;
  timeunit 1ns;
  timeprecision 1ps;
  import xbuf_pkg::*;

  localparam int TD_DEPTH = 64;
  localparam int RESET_CYCLES = 10;

  logic                                        clk_i;
  logic                                        rst_ni;
  logic                                        clear_i;
  logic                                        load_i;
  logic [DATA_W-1:0]                           data_i;
  logic [WIDX_W-1:0]                           width_i;
  logic                                        rst_w_index_i;
  logic                                        pad_setup_i;
  logic [CNT_W-1:0]                            slots_i;
  logic [SLOT_AW-1:0]                          height_i;
  logic                                        h_shift_i;
  logic [ARRAY_W-1:0][ARRAY_H-1:0][ELEM_W-1:0] x_buffer_o;
  logic                                        full_o;
  logic                                        empty_o;
  logic                                        bank_valid_o;

  logic [DATA_W-1:0] tdata [0:TD_DEPTH-1];
  int                scen_start [$];
  int                cur_width;
  int                cur_slots;
  int                cur_exp;
  int                errors;
  int                n_runs;
  int                n_shifts;
  int unsigned       cycles;
  int unsigned       limit_cycles;
  logic [31:0]       rng_state;

  x_buffer uut (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .clear_i       (clear_i),
    .load_i        (load_i),
    .data_i        (data_i),
    .width_i       (width_i),
    .rst_w_index_i (rst_w_index_i),
    .pad_setup_i   (pad_setup_i),
    .slots_i       (slots_i),
    .height_i      (height_i),
    .h_shift_i     (h_shift_i),
    .x_buffer_o    (x_buffer_o),
    .full_o        (full_o),
    .empty_o       (empty_o),
    .bank_valid_o  (bank_valid_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  function automatic logic [31:0] next_rand(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic report_err(input string name, input logic [63:0] exp_v,
                            input logic [63:0] got_v);
    errors++;
    $display("ERR %s expected 0x%0h got 0x%0h at %0t", name, exp_v, got_v, $time);
  endtask

  // Load the pad rows of one scenario, then start the fast fill
  task automatic load_and_setup(input int idx);
    int                start;
    int                lat;
    logic [DATA_W-1:0] hdr;
    start     = scen_start[idx];
    hdr       = tdata[start];
    cur_width = int'(hdr[23:16]);
    cur_slots = int'(hdr[7:0]);
    cur_exp   = start + 1 + cur_width;
    n_runs++;
    @(negedge clk_i);
    width_i  = WIDX_W'(cur_width);
    height_i = hdr[8 +: SLOT_AW];
    slots_i  = CNT_W'(cur_slots);
    for (int w = 0; w < cur_width; w++) begin
      @(negedge clk_i);
      if (full_o !== 1'b0) report_err("full_o", 0, full_o);
      load_i = 1'b1;
      data_i = tdata[start + 1 + w];
    end
    @(negedge clk_i);
    load_i = 1'b0;
    data_i = '0;
    // Full holds until acknowledged
    repeat (3) begin
      if (full_o !== 1'b1) report_err("full_o", 1, full_o);
      @(negedge clk_i);
    end
    pad_setup_i = 1'b1;
    @(negedge clk_i);
    pad_setup_i   = 1'b0;
    rst_w_index_i = 1'b1;
    if (full_o !== 1'b1) report_err("full_o", 1, full_o);
    @(negedge clk_i);
    rst_w_index_i = 1'b0;
    if (full_o !== 1'b0) report_err("full_o", 0, full_o);
    lat = 2;
    while (!bank_valid_o) begin
      @(negedge clk_i);
      lat++;
    end
    if (lat != ARRAY_H + 1) report_err("bank_valid_o latency", ARRAY_H + 1, lat);
  endtask

  // Consume rows at random spacing and check every presented bank
  task automatic deliver_rows(input int n_shift);
    int                done;
    int                gap;
    int                row;
    int                base;
    int                slot;
    logic              exp_empty;
    logic [ELEM_W-1:0] exp_e;
    done = 0;
    gap  = 0;
    row  = 0;
    base = 0;
    h_shift_i = 1'b0;
    while (done < n_shift || h_shift_i) begin
      @(negedge clk_i);
      exp_empty = 1'b0;
      if (h_shift_i) begin
        slot      = (base + row) % cur_slots;
        exp_empty = (slot == cur_slots - 1);
        row++;
        done++;
        n_shifts++;
        if (row == ARRAY_H) begin
          row  = 0;
          base = (base + ARRAY_H) % cur_slots;
        end
      end
      if (empty_o !== exp_empty) report_err("empty_o", exp_empty, empty_o);
      if (bank_valid_o) begin
        for (int h = 0; h < ARRAY_H; h++) begin
          for (int w = 0; w < cur_width; w++) begin
            slot  = (base + h) % cur_slots;
            exp_e = tdata[cur_exp + slot][ELEM_W*w +: ELEM_W];
            if (x_buffer_o[w][h] !== exp_e) begin
              report_err($sformatf("x_buffer_o[%0d][%0d]", w, h), exp_e, x_buffer_o[w][h]);
            end
          end
        end
      end
      if (done < n_shift && bank_valid_o && gap == 0) begin
        h_shift_i = 1'b1;
        rng_state = next_rand(rng_state);
        // Mostly short gaps with a long stall now and then
        gap = (rng_state[3:0] == 4'd0) ? 8 : int'(rng_state[5:4]);
      end else begin
        h_shift_i = 1'b0;
        if (gap > 0) gap--;
      end
    end
  endtask

  // Watchdog
  initial begin
    cycles = 0;
    wait (limit_cycles != 0);
    while (cycles < limit_cycles) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout after %0d cycles, the scenarios did not complete", cycles);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    int pos;
    rst_ni        = 1'b0;
    clear_i       = 1'b0;
    load_i        = 1'b0;
    data_i        = '0;
    width_i       = WIDX_W'(ARRAY_W);
    rst_w_index_i = 1'b0;
    pad_setup_i   = 1'b0;
    slots_i       = CNT_W'(PAD_DEPTH);
    height_i      = '0;
    h_shift_i     = 1'b0;
    errors        = 0;
    n_runs        = 0;
    n_shifts      = 0;
    rng_state     = 32'd50502;
    $readmemh("test/x_buffer_testdata.hex", tdata);
    // A zero width header ends the scenario list
    pos = 0;
    while (pos < TD_DEPTH - 1 && tdata[pos][23:16] != 8'd0) begin
      scen_start.push_back(pos);
      pos = pos + 1 + int'(tdata[pos][23:16]) + int'(tdata[pos][7:0]);
    end
    limit_cycles = RESET_CYCLES + (scen_start.size() + 2) * (ARRAY_W + 4 * PAD_DEPTH + 20);
    repeat (RESET_CYCLES) @(negedge clk_i);
    rst_ni = 1'b1;
    if (scen_start.size() == 0) begin
      errors++;
      $display("No scenarios were found in the data file");
    end else begin
      foreach (scen_start[i]) begin
        load_and_setup(i);
        deliver_rows(cur_slots + ARRAY_H);
      end
      // Clear in the middle of delivery, then run the same scenario afresh
      load_and_setup(0);
      deliver_rows(cur_slots - 1);
      // Reload the pad so full is set, then clear on the shift of the last slot
      for (int w = 0; w < cur_width; w++) begin
        @(negedge clk_i);
        load_i = 1'b1;
        data_i = tdata[scen_start[0] + 1 + w];
      end
      @(negedge clk_i);
      load_i = 1'b0;
      data_i = '0;
      if (full_o !== 1'b1) report_err("full_o", 1, full_o);
      if (bank_valid_o !== 1'b1) report_err("bank_valid_o", 1, bank_valid_o);
      clear_i   = 1'b1;
      h_shift_i = 1'b1;
      @(negedge clk_i);
      clear_i   = 1'b0;
      h_shift_i = 1'b0;
      if (full_o !== 1'b0) report_err("full_o", 0, full_o);
      if (empty_o !== 1'b0) report_err("empty_o", 0, empty_o);
      if (bank_valid_o !== 1'b0) report_err("bank_valid_o", 0, bank_valid_o);
      load_and_setup(0);
      deliver_rows(cur_slots + ARRAY_H);
    end
    @(negedge clk_i);
    $display("Runs %0d, shifts %0d, errors %0d", n_runs, n_shifts, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: test/x_buffer_testdata.hex
// Header 00WWHHSS gives width, height and slots, then width pad rows (slot 0 in low bits),
// then one expected word per slot with column w at bits 16w+15:16w, zero past the height
040708
A007A006A005A004A003A002A001A000
A017A016A015A014A013A012A011A010
A027A026A025A024A023A022A021A020
A037A036A035A034A033A032A031A030
A030A020A010A000
A031A021A011A001
A032A022A012A002
A033A023A013A003
A034A024A014A004
A035A025A015A005
A036A026A016A006
A037A027A017A007
030406
B007B006B005B004B003B002B001B000
B017B016B015B014B013B012B011B010
B027B026B025B024B023B022B021B020
0000B020B010B000
0000B021B011B001
0000B022B012B002
0000B023B013B003
0000B024B014B004
0000000000000000
020104
C007C006C005C004C003C002C001C000
C017C016C015C014C013C012C011C010
00000000C010C000
00000000C011C001
0000000000000000
0000000000000000
000000

// File: project.f
logic/xbuf_pkg.sv
logic/x_pad_mem.sv
logic/x_shift_buf.sv
logic/x_buffer_ctrl.sv
logic/x_buffer.sv
test/x_buffer_asserts.sv
test/tb_x_buffer.sv

// File: Bender.yml
package:
  name: x_buffer

sources:
  - files:
      - logic/xbuf_pkg.sv
      - logic/x_pad_mem.sv
      - logic/x_shift_buf.sv
      - logic/x_buffer_ctrl.sv
      - logic/x_buffer.sv
  - target: test
    files:
      - test/x_buffer_asserts.sv
      - test/tb_x_buffer.sv
